// ==== hdl/rs232_pkg.sv ====
// framing is fixed at 8 data bits, one stop bit and no flow control; TICKS_PER_BIT must be 4 or more
package rs232_pkg;

    //////////////////////////////////////////////////////////////////////
    // character format and bit timing
    //////////////////////////////////////////////////////////////////////

    localparam int DATA_BITS      = 8;                  // lsb goes out first
    localparam int TICKS_PER_BIT  = 16;                 // about 434 for 50 MHz at 115200 bit/s
    localparam int HALF_BIT_TICKS = TICKS_PER_BIT / 2;  // mid-bit sampling point

    typedef enum logic [1:0]
    {
        PARITY_NONE,
        PARITY_EVEN,
        PARITY_ODD
    } parity_mode_e;

    localparam parity_mode_e PARITY_MODE = PARITY_EVEN;

    //////////////////////////////////////////////////////////////////////
    // receive buffer
    //////////////////////////////////////////////////////////////////////

    localparam int RX_FIFO_DEPTH    = 16;  // power of two, pointers wrap on their own
    localparam int RX_FIFO_PTR_BITS = $clog2(RX_FIFO_DEPTH);

    //////////////////////////////////////////////////////////////////////
    // shared types
    //////////////////////////////////////////////////////////////////////

    typedef logic [DATA_BITS-1:0]            rs232_byte_t;
    typedef logic [$clog2(TICKS_PER_BIT)-1:0] bit_tick_t;   // counts 0 .. TICKS_PER_BIT-1
    typedef logic [3:0]                      bit_index_t;
    typedef logic [RX_FIFO_PTR_BITS-1:0]     fifo_ptr_t;
    typedef logic [RX_FIFO_PTR_BITS:0]       fifo_count_t; // one extra bit to hold full

    // one-cycle error pulses toward the user side
    typedef struct packed
    {
        logic parity_err;
        logic frame_err;
        logic overrun;
    } rx_status_t;

endpackage

// ==== hdl/rx_fifo.sv ====
// first-word-fall-through, depth must be a power of two; a push into a full buffer is lost
`timescale 1ns/10ps

module rx_fifo import rs232_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  rs232_byte_t push_data,
    input  logic        push,
    input  logic        pop,
    output rs232_byte_t head_data,
    output logic        valid,
    output logic        overrun
);

    rs232_byte_t mem [RX_FIFO_DEPTH];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;
    logic        full;
    logic        do_push;
    logic        do_pop;

    assign valid     = (count != '0);
    assign full      = (count == fifo_count_t'(RX_FIFO_DEPTH));
    assign do_pop    = pop && valid;            // pop on empty is ignored
    assign do_push   = push && (!full || do_pop); // a pop frees the slot in the same cycle
    assign head_data = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end
        else
        begin
            overrun <= push && !do_push;
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hdl/rs232_tx.sv ====
// level request, one acknowledge pulse per character; tx_data is only read in the accept cycle
`timescale 1ns/10ps

module rs232_tx import rs232_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  rs232_byte_t tx_data,
    input  logic        tx_data_ready,
    output logic        tx,
    output logic        tx_data_copied,
    output logic        tx_busy
);

    typedef enum logic [2:0]
    {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

    tx_state_e   state;
    bit_tick_t   tick;          // cycle within the current bit
    bit_index_t  bit_idx;       // data bit on the line
    rs232_byte_t tx_shift;      // bit 0 is the one on the line
    logic        tx_parity;     // xor of the data bits sent so far
    logic        tick_last;
    logic        accept;

    assign tick_last = (tick == bit_tick_t'(TICKS_PER_BIT - 1));
    assign accept    = (state == TX_IDLE) && tx_data_ready;

    // character shifter, payload only
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            tx_shift <= tx_data;
        end
        else if (state == TX_DATA && tick_last)
        begin
            tx_shift <= {1'b0, tx_shift[DATA_BITS-1:1]};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // frame sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state          <= TX_IDLE;
            tx             <= 1'b1;     // line idles at mark
            tx_data_copied <= 1'b0;
            tx_busy        <= 1'b0;
            tick           <= '0;
            bit_idx        <= '0;
            tx_parity      <= 1'b0;
        end
        else
        begin
            tx_data_copied <= 1'b0;

            if (state != TX_IDLE)
            begin
                tick <= tick_last ? '0 : tick + 1'b1;
            end

            case (state)
                TX_IDLE:
                begin
                    if (tx_data_ready)
                    begin
                        state          <= TX_START;
                        tx             <= 1'b0;    // start bit
                        tx_busy        <= 1'b1;
                        tx_data_copied <= 1'b1;
                        tick           <= '0;
                        bit_idx        <= '0;
                    end
                end
                TX_START:
                begin
                    if (tick_last)
                    begin
                        state     <= TX_DATA;
                        tx        <= tx_shift[0];
                        tx_parity <= tx_shift[0];
                    end
                end
                TX_DATA:
                begin
                    if (tick_last)
                    begin
                        if (bit_idx == bit_index_t'(DATA_BITS - 1))
                        begin
                            if (PARITY_MODE == PARITY_NONE)
                            begin
                                state <= TX_STOP;
                                tx    <= 1'b1;
                            end
                            else
                            begin
                                // odd mode inverts so the total count of ones is odd
                                state <= TX_PARITY;
                                tx    <= tx_parity ^ (PARITY_MODE == PARITY_ODD);
                            end
                        end
                        else
                        begin
                            tx        <= tx_shift[1];     // shifter moves on this same edge
                            tx_parity <= tx_parity ^ tx_shift[1];
                            bit_idx   <= bit_idx + 1'b1;
                        end
                    end
                end
                TX_PARITY:
                begin
                    if (tick_last)
                    begin
                        state <= TX_STOP;
                        tx    <= 1'b1;
                    end
                end
                TX_STOP:
                begin
                    if (tick_last)
                    begin
                        state   <= TX_IDLE;
                        tx_busy <= 1'b0;
                    end
                end
                default:
                begin
                    state <= TX_IDLE;
                    tx    <= 1'b1;
                end
            endcase
        end
    end

endmodule

// ==== hdl/rs232_rx.sv ====
// rx is asynchronous and gets two sync flops; only one error is flagged per frame, framing first
`timescale 1ns/10ps

module rs232_rx import rs232_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        rx,
    output rs232_byte_t rx_char,
    output logic        rx_char_strobe,
    output logic        parity_err,
    output logic        frame_err
);

    typedef enum logic [2:0]
    {
        RX_IDLE,
        RX_START_CHECK,
        RX_DATA,
        RX_PARITY,
        RX_STOP,
        RX_REARM
    } rx_state_e;

    rx_state_e  state;
    logic       rx_meta;
    logic       rx_sync;
    bit_tick_t  tick;
    bit_index_t bit_idx;
    logic       data_parity;    // running xor of the sampled data bits
    logic       parity_bad;
    logic       parity_expected;
    logic       tick_last;
    logic       half_last;
    logic       sample_data;

    assign tick_last       = (tick == bit_tick_t'(TICKS_PER_BIT - 1));
    assign half_last       = (tick == bit_tick_t'(HALF_BIT_TICKS - 1));
    assign sample_data     = (state == RX_DATA) && tick_last;
    assign parity_expected = data_parity ^ (PARITY_MODE == PARITY_ODD);

    // two-flop synchronizer, held at mark during reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge clk)
    begin
        if (sample_data)
        begin
            rx_char <= {rx_sync, rx_char[DATA_BITS-1:1]};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // frame sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state          <= RX_IDLE;
            tick           <= '0;
            bit_idx        <= '0;
            data_parity    <= 1'b0;
            parity_bad     <= 1'b0;
            rx_char_strobe <= 1'b0;
            parity_err     <= 1'b0;
            frame_err      <= 1'b0;
        end
        else
        begin
            rx_char_strobe <= 1'b0;
            parity_err     <= 1'b0;
            frame_err      <= 1'b0;

            case (state)
                RX_IDLE:
                begin
                    tick <= '0;
                    if (!rx_sync)
                    begin
                        state <= RX_START_CHECK;    // falling edge, line was high to get here
                    end
                end
                RX_START_CHECK:
                begin
                    tick <= tick + 1'b1;
                    if (half_last)
                    begin
                        // still low at mid start bit, otherwise it was a glitch
                        state       <= rx_sync ? RX_IDLE : RX_DATA;
                        tick        <= '0;
                        bit_idx     <= '0;
                        data_parity <= 1'b0;
                        parity_bad  <= 1'b0;
                    end
                end
                RX_DATA:
                begin
                    tick <= tick_last ? '0 : tick + 1'b1;
                    if (tick_last)
                    begin
                        data_parity <= data_parity ^ rx_sync;
                        bit_idx     <= bit_idx + 1'b1;
                        if (bit_idx == bit_index_t'(DATA_BITS - 1))
                        begin
                            state <= (PARITY_MODE == PARITY_NONE) ? RX_STOP : RX_PARITY;
                        end
                    end
                end
                RX_PARITY:
                begin
                    tick <= tick_last ? '0 : tick + 1'b1;
                    if (tick_last)
                    begin
                        parity_bad <= (rx_sync != parity_expected);
                        state      <= RX_STOP;
                    end
                end
                RX_STOP:
                begin
                    tick <= tick_last ? '0 : tick + 1'b1;
                    if (tick_last)
                    begin
                        state <= RX_REARM;
                        // a low stop bit means the frame is misaligned, parity is moot then
                        if (!rx_sync)
                        begin
                            frame_err <= 1'b1;
                        end
                        else if (parity_bad)
                        begin
                            parity_err <= 1'b1;
                        end
                        else
                        begin
                            rx_char_strobe <= 1'b1;
                        end
                    end
                end
                RX_REARM:
                begin
                    if (rx_sync)
                    begin
                        state <= RX_IDLE;   // wait for mark before the next start
                    end
                end
                default:
                begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/quick_rs232.sv ====
// RS-232 port without flow control; rx_status bits are single-cycle pulses, rx_valid is a level
`timescale 1ns/10ps

module quick_rs232 import rs232_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // serial line
    input  logic        rx,
    output logic        tx,
    // transmit side
    input  rs232_byte_t tx_data,
    input  logic        tx_data_ready,
    output logic        tx_data_copied,
    output logic        tx_busy,
    // receive side
    output rs232_byte_t rx_data,
    output logic        rx_valid,
    input  logic        rx_read,
    output rx_status_t  rx_status
);

    rs232_byte_t rx_char;
    logic        rx_char_strobe;
    logic        rx_parity_err;
    logic        rx_frame_err;
    logic        fifo_overrun;

    //////////////////////////////////////////////////////////////////////
    // transmitter
    //////////////////////////////////////////////////////////////////////

    rs232_tx rs232_tx_i
    (
        .clk            (clk),
        .rst            (rst),
        .tx_data        (tx_data),
        .tx_data_ready  (tx_data_ready),
        .tx             (tx),
        .tx_data_copied (tx_data_copied),
        .tx_busy        (tx_busy)
    );

    //////////////////////////////////////////////////////////////////////
    // receiver and its buffer
    //////////////////////////////////////////////////////////////////////

    rs232_rx rs232_rx_i
    (
        .clk            (clk),
        .rst            (rst),
        .rx             (rx),
        .rx_char        (rx_char),
        .rx_char_strobe (rx_char_strobe),
        .parity_err     (rx_parity_err),
        .frame_err      (rx_frame_err)
    );

    rx_fifo rx_fifo_i
    (
        .clk       (clk),
        .rst       (rst),
        .push_data (rx_char),
        .push      (rx_char_strobe),   // only good characters get here
        .pop       (rx_read),
        .head_data (rx_data),
        .valid     (rx_valid),
        .overrun   (fifo_overrun)
    );

    assign rx_status.parity_err = rx_parity_err;
    assign rx_status.frame_err  = rx_frame_err;
    assign rx_status.overrun    = fifo_overrun;

endmodule

// ==== verification/rs232_tb_model.svh ====
// wire-level model of one frame; sample_frame reads tx once per bit near mid-bit, on falling edges
`ifndef RS232_TB_MODEL_SVH
`define RS232_TB_MODEL_SVH

localparam int PARITY_BITS = (PARITY_MODE == PARITY_NONE) ? 0 : 1;
localparam int FRAME_BITS  = DATA_BITS + 2 + PARITY_BITS;

typedef logic [FRAME_BITS-1:0] frame_t;    // bit 0 is the start bit, msb the stop bit

// parity bit that makes the count of ones even or odd
function automatic logic expected_parity(input rs232_byte_t b);
    return (PARITY_MODE == PARITY_ODD) ? ~(^b) : ^b;
endfunction

function automatic frame_t expected_frame(input rs232_byte_t b);
    frame_t f;
    f = '0;                                // start bit low
    f[DATA_BITS:1] = b;                    // lsb first on the wire
    if (PARITY_BITS != 0)
    begin
        f[DATA_BITS+1] = expected_parity(b);
    end
    f[FRAME_BITS-1] = 1'b1;
    return f;
endfunction

task automatic drive_frame(input rs232_byte_t b, input logic bad_parity, input logic bad_stop);
    frame_t f;
    int     i;
    f = expected_frame(b);
    if (bad_parity && PARITY_BITS != 0)
    begin
        f[DATA_BITS+1] = ~f[DATA_BITS+1];
    end
    if (bad_stop)
    begin
        f[FRAME_BITS-1] = 1'b0;
    end
    @(negedge clk);
    for (i = 0; i < FRAME_BITS; i++)
    begin
        rx = f[i];
        repeat (TICKS_PER_BIT) @(negedge clk);
    end
    rx = 1'b1;                             // back to mark
endtask

task automatic sample_frame(input int max_wait, output frame_t f, output logic found);
    int waited;
    int i;
    f      = '0;
    found  = 1'b0;
    waited = 0;
    @(negedge clk);
    while (tx !== 1'b0 && waited < max_wait)
    begin
        @(negedge clk);
        waited++;
    end
    if (tx === 1'b0)
    begin
        found = 1'b1;
        repeat (HALF_BIT_TICKS - 1) @(negedge clk);
        f[0] = tx;
        for (i = 1; i < FRAME_BITS; i++)
        begin
            repeat (TICKS_PER_BIT) @(negedge clk);
            f[i] = tx;
        end
    end
endtask

`endif

// ==== verification/quick_rs232_tb.sv ====
// inputs change on falling edges and outputs are read there too; every wait gives up after a bound
`timescale 1ns/10ps

module quick_rs232_tb import rs232_pkg::*;
();

    localparam int W_COPIED  = 0;
    localparam int W_TX_IDLE = 1;
    localparam int W_VALID   = 2;
    localparam int W_STATUS  = 3;

    logic        clk = 1'b0;
    logic        rst;
    logic        rx;
    logic        tx;
    rs232_byte_t tx_data;
    logic        tx_data_ready;
    logic        tx_data_copied;
    logic        tx_busy;
    rs232_byte_t rx_data;
    logic        rx_valid;
    logic        rx_read;
    rx_status_t  rx_status;

    integer      seed = 32'h1a49fb7c;
    int          value_errors = 0;
    int          other_errors = 0;
    int          copied_cnt = 0;
    int          parity_cnt = 0;
    int          frame_cnt = 0;
    int          overrun_cnt = 0;
    int          status_mark = 0;
    int          busy_len = 0;
    int          busy_lengths[$];

    `include "rs232_tb_model.svh"

    always #5 clk = ~clk;

    quick_rs232 quick_rs232_i
    (
        .clk            (clk),
        .rst            (rst),
        .rx             (rx),
        .tx             (tx),
        .tx_data        (tx_data),
        .tx_data_ready  (tx_data_ready),
        .tx_data_copied (tx_data_copied),
        .tx_busy        (tx_busy),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .rx_read        (rx_read),
        .rx_status      (rx_status)
    );

    //////////////////////////////////////////////////////////////////////
    // monitor, counts pulses and measures each busy period
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (tx_data_copied) copied_cnt++;
            if (rx_status.parity_err) parity_cnt++;
            if (rx_status.frame_err) frame_cnt++;
            if (rx_status.overrun) overrun_cnt++;
            if (tx_busy)
            begin
                busy_len++;
            end
            else if (busy_len != 0)
            begin
                busy_lengths.push_back(busy_len);   // one entry per frame
                busy_len = 0;
            end
        end
    end

    function automatic int status_total();
        return parity_cnt + frame_cnt + overrun_cnt;
    endfunction

    function automatic rs232_byte_t random_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[DATA_BITS-1:0];
    endfunction

    function automatic logic condition_met(input int which);
        case (which)
            W_COPIED:  return tx_data_copied === 1'b1;
            W_TX_IDLE: return tx_busy === 1'b0;
            W_VALID:   return rx_valid === 1'b1;
            default:   return status_total() != status_mark;
        endcase
    endfunction

    task automatic count_failure(input string what);
        $display("ERROR: %s", what);
        other_errors++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic wait_until(input int which, input int max_cycles, input string what,
                              output logic ok);
        int waited;
        waited = 0;
        while (!condition_met(which) && waited < max_cycles)
        begin
            @(negedge clk);
            waited++;
        end
        ok = condition_met(which);
        if (!ok)
        begin
            count_failure($sformatf("%s did not arrive within %0d cycles", what, max_cycles));
        end
    endtask

    task automatic send_byte(input rs232_byte_t b);
        logic ok;
        @(negedge clk);
        tx_data       = b;
        tx_data_ready = 1'b1;
        wait_until(W_COPIED, 4 * TICKS_PER_BIT, "tx_data_copied", ok);
        tx_data_ready = 1'b0;
    endtask

    task automatic read_byte(output rs232_byte_t b);
        logic ok;
        wait_until(W_VALID, 4 * FRAME_BITS * TICKS_PER_BIT, "rx_valid", ok);
        b = rx_data;
        if (ok)
        begin
            rx_read = 1'b1;
            @(negedge clk);
            rx_read = 1'b0;
        end
    endtask

    task automatic check_busy_lengths(input int n);
        int i;
        for (i = 0; i < n; i++)
        begin
            if (busy_lengths.size() == 0)
            begin
                count_failure("a tx_busy period is missing");
            end
            else
            begin
                check_value("tx_busy cycles", busy_lengths.pop_front(), FRAME_BITS * TICKS_PER_BIT);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    rs232_byte_t b;
    rs232_byte_t got_byte;
    rs232_byte_t burst [3];
    rs232_byte_t held [17];
    frame_t      got_frame;
    logic        found;
    logic        ok;
    int          n;
    int          j;
    int          k;
    int          copies_before;
    int          status_before;

    initial
    begin
        rst           = 1'b1;
        rx            = 1'b1;
        tx_data       = '0;
        tx_data_ready = 1'b0;
        rx_read       = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("tx", tx, 1'b1);
        check_value("tx_busy", tx_busy, 1'b0);
        check_value("rx_valid", rx_valid, 1'b0);
        check_value("rx_status", rx_status, 3'b000);

        // single frames, one acknowledge each
        for (n = 0; n < 20; n++)
        begin
            b = random_byte();
            copies_before = copied_cnt;
            fork
                send_byte(b);
                sample_frame(8 * TICKS_PER_BIT, got_frame, found);
            join
            if (!found) count_failure("no start bit seen on tx");
            check_value("tx frame", got_frame, expected_frame(b));
            wait_until(W_TX_IDLE, 2 * TICKS_PER_BIT, "tx_busy low", ok);
            @(negedge clk);
            check_value("tx_data_copied pulses", copied_cnt - copies_before, 1);
            check_busy_lengths(1);
        end

        // request held high over three characters
        for (n = 0; n < 3; n++) burst[n] = random_byte();
        copies_before = copied_cnt;
        fork
            begin
                @(negedge clk);
                tx_data       = burst[0];
                tx_data_ready = 1'b1;
                for (k = 0; k < 3; k++)
                begin
                    wait_until(W_COPIED, 2 * FRAME_BITS * TICKS_PER_BIT, "tx_data_copied", ok);
                    if (k < 2) tx_data = burst[k+1];
                    @(negedge clk);
                end
                tx_data_ready = 1'b0;
            end
            begin
                for (j = 0; j < 3; j++)
                begin
                    sample_frame((j == 0) ? 8 * TICKS_PER_BIT : TICKS_PER_BIT, got_frame, found);
                    if (!found) count_failure("back-to-back frame did not start in time");
                    check_value("tx burst frame", got_frame, expected_frame(burst[j]));
                end
            end
        join
        wait_until(W_TX_IDLE, 2 * TICKS_PER_BIT, "tx_busy low", ok);
        @(negedge clk);
        check_value("tx_data_copied pulses", copied_cnt - copies_before, 3);
        check_busy_lengths(3);

        // good characters, read out one by one
        status_before = status_total();
        for (n = 0; n < 10; n++)
        begin
            b = random_byte();
            drive_frame(b, 1'b0, 1'b0);
            read_byte(got_byte);
            check_value("rx_data", got_byte, b);
            check_value("rx_valid", rx_valid, 1'b0);
        end
        check_value("rx_status pulses", status_total() - status_before, 0);

        // parity error, then framing error, then a good one
        b = random_byte();
        if (PARITY_BITS != 0)
        begin
            status_mark   = status_total();
            status_before = parity_cnt;
            drive_frame(b, 1'b1, 1'b0);
            wait_until(W_STATUS, 2 * TICKS_PER_BIT, "parity_err", ok);
            check_value("parity_err pulses", parity_cnt - status_before, 1);
            check_value("rx_valid", rx_valid, 1'b0);
        end
        status_mark   = status_total();
        status_before = frame_cnt;
        drive_frame(b, 1'b0, 1'b1);
        repeat (TICKS_PER_BIT) @(negedge clk);    // line back at mark so the receiver rearms
        wait_until(W_STATUS, 2 * TICKS_PER_BIT, "frame_err", ok);
        check_value("frame_err pulses", frame_cnt - status_before, 1);
        check_value("rx_valid", rx_valid, 1'b0);
        drive_frame(b, 1'b0, 1'b0);
        read_byte(got_byte);
        check_value("rx_data", got_byte, b);

        // seventeen frames into a sixteen deep buffer
        status_mark   = status_total();
        status_before = overrun_cnt;
        for (n = 0; n < 17; n++)
        begin
            held[n] = random_byte();
            drive_frame(held[n], 1'b0, 1'b0);
        end
        wait_until(W_STATUS, 2 * TICKS_PER_BIT, "overrun", ok);
        check_value("overrun pulses", overrun_cnt - status_before, 1);
        for (n = 0; n < 16; n++)
        begin
            read_byte(got_byte);
            check_value("rx_data", got_byte, held[n]);
        end
        check_value("rx_valid", rx_valid, 1'b0);

        // short low pulse, must be rejected as a glitch
        status_mark = status_total();
        @(negedge clk);
        rx = 1'b0;
        repeat (HALF_BIT_TICKS - 2) @(negedge clk);
        rx = 1'b1;
        repeat ((FRAME_BITS + 2) * TICKS_PER_BIT) @(negedge clk);  // a false frame would end by now
        check_value("rx_valid", rx_valid, 1'b0);
        check_value("rx_status pulses", status_total() - status_mark, 0);

        $display("summary: %0d value mismatches, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+verification
hdl/rs232_pkg.sv
hdl/rx_fifo.sv
hdl/rs232_tx.sv
hdl/rs232_rx.sv
hdl/quick_rs232.sv
verification/quick_rs232_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the RS-232 testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
BIN=quick_rs232_sim

verilator --binary --timing -Wno-fatal \
    --top-module quick_rs232_tb \
    --Mdir "$BUILD_DIR" -o "$BIN" \
    -f flist.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $LOG"
exit 1
